//--- source/link_frame_pkg.sv
/*
 * strip link frame format
 * word, packet and frame layout of the detector link: six 20-bit words
 * make one 120-bit frame that carries four 30-bit packets
 */
package link_frame_pkg;

    // input side
    localparam int word_width      = 20;
    localparam int words_per_frame = 6;
    localparam int frame_width     = word_width * words_per_frame;  // 120

    // packet layout inside a frame
    localparam int packet_width      = 30;
    localparam int packets_per_frame = 4;
    localparam int header_width      = 4;
    localparam int payload_width     = packet_width - header_width;  // 26

    // the two legal packet headers
    localparam logic [header_width-1:0] hdr_data = 4'b1010;
    localparam logic [header_width-1:0] hdr_mark = 4'b1100;

    // bit offset of the frame boundary, 0..frame_width-1
    typedef logic [$clog2(frame_width)-1:0] offset_t;

    typedef logic [word_width-1:0] rx_word_t;

    typedef struct packed {
        logic [header_width-1:0]  header;
        logic [payload_width-1:0] payload;
    } packet_t;

    // packet 3 sits in the top bits and goes out first
    typedef packet_t [packets_per_frame-1:0] frame_t;

endpackage

//--- source/link_sync_pkg.sv
/*
 * strip link sync definitions
 * states and thresholds of the frame lock search, and the
 * 19-bit status word reported to the outside
 */
package link_sync_pkg;

    // encodings kept from the original link firmware
    typedef enum logic [3:0] {
        idle         = 4'd0,
        wait_phase   = 4'd1,
        check        = 4'd2,
        judge        = 4'd3,
        locked_wait  = 4'd4,
        locked_check = 4'd5
    } sync_state_t;

    typedef logic [8:0] sync_cnt_t;
    typedef logic [4:0] err_cnt_t;

    // lock needs more good frames than this
    localparam sync_cnt_t lock_threshold = 9'd508;

    // offset moves on once search errors pass this
    localparam err_cnt_t search_err_max = 5'd4;

    // lock needs fewer errors than this
    localparam err_cnt_t lock_err_max = 5'd3;

    // error count that drops an established lock
    localparam err_cnt_t unlock_err = 5'd16;

    typedef struct packed {
        sync_state_t state;     // [18:15]
        logic        locked;    // [14]
        sync_cnt_t   sync_cnt;  // [13:5]
        err_cnt_t    err_cnt;   // [4:0]
    } link_status_t;

endpackage

//--- source/word_gatherer.sv
/*
 * word gatherer
 * shifts in one link word per cycle and captures six of them into a
 * raw frame every six cycles; also flags a stuck line when the five
 * newest words are all equal
 */
`timescale 1ns/1ps

module word_gatherer import link_frame_pkg::*; (
    input  logic     clk160,
    input  logic     system_reset_r2,
    input  rx_word_t rx_word,
    output frame_t   frame,
    output logic     frame_strobe,
    output logic     stuck_line
);

    logic [2:0]                     phase;
    logic                           last_phase;
    rx_word_t [words_per_frame-1:0] word_chain;  // [0] is the newest word
    rx_word_t [words_per_frame-1:0] chain_next;

    assign last_phase = (phase == 3'(words_per_frame - 1));

    // oldest word ends up in the top bits
    assign chain_next = {word_chain[words_per_frame-2:0], rx_word};

    // free running mod-6 phase
    always_ff @(posedge clk160) begin
        if (system_reset_r2) begin
            phase        <= '0;
            frame_strobe <= 1'b0;
        end else begin
            phase        <= last_phase ? 3'd0 : phase + 3'd1;
            frame_strobe <= last_phase;  // high with the freshly captured frame
        end
    end

    always_ff @(posedge clk160) begin
        word_chain <= chain_next;
        if (last_phase)
            frame <= chain_next;  // phase-5 word goes in as the newest
    end

    // line stuck at one pattern, e.g. a dead transmitter
    assign stuck_line = (word_chain[0] == word_chain[1]) &&
                        (word_chain[1] == word_chain[2]) &&
                        (word_chain[2] == word_chain[3]) &&
                        (word_chain[3] == word_chain[4]);

    // frame period must stay exactly six words
    phase_in_range: assert property (
        @(posedge clk160) disable iff (system_reset_r2)
        phase < 3'(words_per_frame)
    );

endmodule

//--- source/frame_aligner.sv
/*
 * frame aligner
 * keeps the previous raw frame and cuts a 120-bit window across the
 * frame boundary at the bit offset chosen by the sync tracker
 */
`timescale 1ns/1ps

module frame_aligner import link_frame_pkg::*; (
    input  logic    clk160,
    input  logic    system_reset_r2,
    input  frame_t  frame,
    input  logic    frame_strobe,
    input  offset_t offset,
    output frame_t  aligned,
    output logic    aligned_strobe
);

    frame_t                   prev_frame;
    logic [2*frame_width-1:0] frame_pair;   // older frame on top
    logic [7:0]               window_base;

    assign frame_pair = {prev_frame, frame};

    // offset n keeps the low n+1 bits of the older frame
    assign window_base = {1'b0, offset} + 8'd1;

    always_ff @(posedge clk160) begin
        if (frame_strobe) begin
            prev_frame <= frame;
            aligned    <= frame_pair[window_base +: frame_width];
        end
    end

    always_ff @(posedge clk160) begin
        if (system_reset_r2)
            aligned_strobe <= 1'b0;
        else
            aligned_strobe <= frame_strobe;
    end

    // offset search in the tracker must wrap before the window leaves the pair
    offset_in_frame: assert property (
        @(posedge clk160) disable iff (system_reset_r2)
        offset < frame_width
    );

endmodule

//--- source/sync_tracker.sv
/*
 * sync tracker
 * checks the four packet headers of every aligned frame, slides the
 * bit offset until the headers line up, then holds lock until too
 * many bad frames arrive; drives the link status word
 */
`timescale 1ns/1ps

module sync_tracker import link_frame_pkg::*; import link_sync_pkg::*; (
    input  logic         clk160,
    input  logic         system_reset_r2,
    input  frame_t       aligned,
    input  logic         aligned_strobe,
    input  logic         stuck_line,
    output offset_t      offset,
    output link_status_t link_status
);

    sync_state_t state;
    sync_cnt_t   sync_cnt;
    err_cnt_t    err_cnt;
    err_cnt_t    err_next;
    logic        frame_good;
    logic        in_lock;

    // all four headers must be a known code
    always_comb begin
        frame_good = 1'b1;
        for (int i = 0; i < packets_per_frame; i++) begin
            if (aligned[i].header != hdr_data && aligned[i].header != hdr_mark)
                frame_good = 1'b0;
        end
    end

    assign err_next = frame_good ? err_cnt : err_cnt + 5'd1;
    assign in_lock  = (state == locked_wait) || (state == locked_check);

    always_ff @(posedge clk160) begin
        if (system_reset_r2) begin
            state    <= idle;
            sync_cnt <= '0;
            err_cnt  <= '0;
            offset   <= '0;
        end else begin
            case (state)
                idle: begin
                    if (aligned_strobe) begin  // fresh search at this offset
                        sync_cnt <= '0;
                        err_cnt  <= '0;
                        state    <= check;
                    end
                end
                wait_phase: begin
                    if (aligned_strobe)
                        state <= check;
                end
                check: begin
                    // frame stays held after its strobe
                    if (frame_good && sync_cnt != '1)
                        sync_cnt <= sync_cnt + 9'd1;
                    err_cnt <= err_next;
                    state   <= judge;
                end
                judge: begin
                    if (sync_cnt > lock_threshold && err_cnt < lock_err_max) begin
                        state <= locked_wait;
                    end else if (err_cnt > search_err_max) begin
                        offset <= (offset == offset_t'(frame_width - 1)) ? '0 : offset + 7'd1;
                        state  <= idle;
                    end else begin
                        state <= wait_phase;
                    end
                end
                locked_wait: begin
                    if (aligned_strobe)
                        state <= locked_check;
                end
                locked_check: begin
                    err_cnt <= err_next;
                    state   <= (err_next == unlock_err) ? idle : locked_wait;
                end
                default: state <= idle;
            endcase
        end
    end

    // status refreshed every cycle
    always_ff @(posedge clk160) begin
        if (system_reset_r2)
            link_status <= '{state: idle, locked: 1'b0, sync_cnt: '0, err_cnt: '0};
        else
            link_status <= '{state:    state,
                             locked:   in_lock && !stuck_line,
                             sync_cnt: sync_cnt,
                             err_cnt:  err_cnt};
    end

    // lock only ever follows a full run of good frames
    locked_after_hits: assert property (
        @(posedge clk160) disable iff (system_reset_r2)
        link_status.locked |-> link_status.sync_cnt > lock_threshold
    );

endmodule

//--- source/packet_serializer.sv
/*
 * packet serializer
 * takes each aligned frame and sends its four packets on
 * consecutive cycles, packet 3 first; idle for the other two cycles
 */
`timescale 1ns/1ps

module packet_serializer import link_frame_pkg::*; (
    input  logic    clk160,
    input  logic    system_reset_r2,
    input  frame_t  aligned,
    input  logic    aligned_strobe,
    output packet_t packet,
    output logic    packet_valid
);

    frame_t     held_frame;
    logic [1:0] packet_idx;  // counts down 3..0
    logic       active;

    always_ff @(posedge clk160) begin
        if (aligned_strobe)
            held_frame <= aligned;
    end

    always_ff @(posedge clk160) begin
        if (system_reset_r2) begin
            active     <= 1'b0;
            packet_idx <= '0;
        end else if (aligned_strobe) begin
            active     <= 1'b1;
            packet_idx <= 2'(packets_per_frame - 1);
        end else if (active) begin
            packet_idx <= packet_idx - 2'd1;
            if (packet_idx == 2'd0)
                active <= 1'b0;  // last packet out
        end
    end

    assign packet       = held_frame[packet_idx];
    assign packet_valid = active;

    // frame period upstream leaves room for all four packets
    no_overrun: assert property (
        @(posedge clk160) disable iff (system_reset_r2)
        aligned_strobe |-> !active
    );

endmodule

//--- source/strip_link_top.sv
/*
 * strip link receiver top
 * word gatherer, frame aligner, sync tracker and packet
 * serializer in one clk160 receive chain
 */
`timescale 1ns/1ps

module strip_link_top import link_frame_pkg::*; import link_sync_pkg::*; (
    input  logic         clk160,
    input  logic         system_reset_r2,
    input  rx_word_t     rx_word,
    output packet_t      packet,
    output logic         packet_valid,
    output link_status_t link_status
);

    frame_t  raw_frame;
    logic    frame_strobe;
    logic    stuck_line;
    frame_t  aligned;
    logic    aligned_strobe;
    offset_t offset;

    word_gatherer word_gatherer_i (
        .clk160          (clk160),
        .system_reset_r2 (system_reset_r2),
        .rx_word         (rx_word),
        .frame           (raw_frame),
        .frame_strobe    (frame_strobe),
        .stuck_line      (stuck_line)
    );

    frame_aligner frame_aligner_i (
        .clk160          (clk160),
        .system_reset_r2 (system_reset_r2),
        .frame           (raw_frame),
        .frame_strobe    (frame_strobe),
        .offset          (offset),
        .aligned         (aligned),
        .aligned_strobe  (aligned_strobe)
    );

    sync_tracker sync_tracker_i (
        .clk160          (clk160),
        .system_reset_r2 (system_reset_r2),
        .aligned         (aligned),
        .aligned_strobe  (aligned_strobe),
        .stuck_line      (stuck_line),
        .offset          (offset),
        .link_status     (link_status)
    );

    packet_serializer packet_serializer_i (
        .clk160          (clk160),
        .system_reset_r2 (system_reset_r2),
        .aligned         (aligned),
        .aligned_strobe  (aligned_strobe),
        .packet          (packet),
        .packet_valid    (packet_valid)
    );

endmodule

//--- tests/strip_link_tb.sv
/*
 * strip link receiver testbench
 * sends a counter stream at a random bit skew, waits for lock, then
 * checks packets, the valid pattern, a stuck line and loss of lock
 */
`timescale 1ns/1ps

module strip_link_tb import link_frame_pkg::*; import link_sync_pkg::*; ();

    localparam int check_packets = 400;
    // full offset sweep, the lock run and the later tests, doubled for margin
    localparam int timeout_cycles = 2 * words_per_frame *
        (frame_width * 6 + lock_threshold + 2 + check_packets / packets_per_frame + 200);

    logic         clk160;
    logic         system_reset_r2;
    rx_word_t     rx_word;
    packet_t      packet;
    logic         packet_valid;
    link_status_t link_status;

    integer     seed;
    int         skew;          // bits the line is delayed by
    int         start_cnt;
    int         word_idx;      // next stream word to send
    int         corrupt_from;  // first frame sent with broken headers
    logic       stuck_mode;
    logic       checks_on;
    int         checked_packets;
    int         error_count;
    int         cycle_count;
    logic [5:0] valid_hist;
    int         hist_len;
    int         pkt_idx;

    strip_link_top dut_i (
        .clk160          (clk160),
        .system_reset_r2 (system_reset_r2),
        .rx_word         (rx_word),
        .packet          (packet),
        .packet_valid    (packet_valid),
        .link_status     (link_status)
    );

    initial begin
        clk160 = 1'b0;
        forever #5 clk160 = ~clk160;
    end

    // frame k holds four data packets that carry a running counter
    function automatic frame_t make_frame(input int k);
        frame_t f;
        for (int p = 0; p < packets_per_frame; p++) begin
            f[p].header  = hdr_data;
            f[p].payload = payload_width'(start_cnt + packets_per_frame * k
                                          + packets_per_frame - 1 - p);
        end
        return f;
    endfunction

    // q counts packets in line order
    function automatic packet_t expected_packet(input int q);
        frame_t f;
        f = make_frame(q / packets_per_frame);
        return f[packets_per_frame - 1 - q % packets_per_frame];
    endfunction

    function automatic rx_word_t stream_word(input int w);
        rx_word_t               word;
        frame_t                 f;
        logic [frame_width-1:0] bits;
        int                     pos;
        for (int m = 0; m < word_width; m++) begin
            pos = w * word_width + m + frame_width - skew;  // msb goes first
            f   = make_frame(pos / frame_width);
            if (pos / frame_width >= corrupt_from)
                for (int p = 0; p < packets_per_frame; p++)
                    f[p].header = 4'b0110;
            bits = f;
            word[word_width - 1 - m] = bits[frame_width - 1 - pos % frame_width];
        end
        return word;
    endfunction

    task automatic abort_run(input string line);
        $display("%s", line);
        $display("Regression failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic report_mismatch(input string msg);
        error_count++;
        abort_run($sformatf("FAIL at time %0t: %s", $time, msg));
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp)
            report_mismatch($sformatf("%s: got %b, expected %b", what, got, exp));
    endtask

    task automatic check_packet(input packet_t got, input packet_t exp);
        if (got !== exp)
            report_mismatch($sformatf("packet header %h payload %0d, expected %h %0d",
                                      got.header, got.payload, exp.header, exp.payload));
    endtask

    task automatic check_status(input link_status_t got, input link_status_t exp,
                                input string what);
        if (got !== exp)
            report_mismatch($sformatf("%s: got %0d/%b/%0d/%0d, expected %0d/%b/%0d/%0d",
                what, got.state, got.locked, got.sync_cnt, got.err_cnt,
                exp.state, exp.locked, exp.sync_cnt, exp.err_cnt));
    endtask

    always @(posedge clk160) begin
        rx_word  <= stuck_mode ? '0 : stream_word(word_idx);
        word_idx <= word_idx + 1;
    end

    always @(posedge clk160) begin
        cycle_count++;
        if (cycle_count >= timeout_cycles)
            abort_run($sformatf("timeout: run not done after %0d cycles", timeout_cycles));
    end

    // packet stream and valid pattern checks
    always @(negedge clk160) begin
        if (!checks_on) begin
            valid_hist = '0;
            hist_len   = 0;
            pkt_idx    = -1;
        end else begin
            valid_hist = {valid_hist[4:0], packet_valid};
            hist_len++;
            if (hist_len >= 6 && $countones(valid_hist) != packets_per_frame)
                report_mismatch("packet_valid not high for four of six cycles");
            if (packet_valid) begin
                if (pkt_idx < 0)
                    pkt_idx = int'(packet.payload) - start_cnt;  // first one sets the place
                // only packets already on the line can come out
                if (pkt_idx < 0 ||
                    pkt_idx * packet_width >= word_idx * word_width + frame_width)
                    report_mismatch($sformatf("payload %0d was never sent", packet.payload));
                check_packet(packet, expected_packet(pkt_idx));
                pkt_idx++;
                checked_packets++;
            end
        end
    end

    initial begin
        link_status_t exp_status;
        logic         saw_drop;
        err_cnt_t     last_err;

        seed            = 99858;
        skew            = ($random(seed) & 32'h7fff_ffff) % frame_width;
        start_cnt       = 1024 + ($random(seed) & 1023);  // no long zero runs on the line
        corrupt_from    = 1 << 30;
        stuck_mode      = 1'b0;
        checks_on       = 1'b0;
        checked_packets = 0;
        error_count     = 0;
        cycle_count     = 0;
        system_reset_r2 = 1'b1;
        rx_word         = stream_word(0);
        word_idx        = 1;
        $display("bit skew %0d, start count %0d", skew, start_cnt);

        repeat (3) @(posedge clk160);
        system_reset_r2 <= 1'b0;
        @(negedge clk160);
        check_flag(packet_valid, 1'b0, "packet_valid after reset");
        exp_status = '{state: idle, locked: 1'b0, sync_cnt: '0, err_cnt: '0};
        check_status(link_status, exp_status, "status after reset");

        // first judge with one hit above the threshold takes the lock
        while (!link_status.locked)
            @(negedge clk160);
        exp_status = '{state: locked_wait, locked: 1'b1,
                       sync_cnt: lock_threshold + 9'd1, err_cnt: '0};
        check_status(link_status, exp_status, "status at lock");

        @(posedge clk160);
        checks_on = 1'b1;
        while (checked_packets < check_packets)
            @(posedge clk160);
        checks_on = 1'b0;

        @(negedge clk160);
        stuck_mode = 1'b1;  // dead transmitter
        saw_drop   = 1'b0;
        repeat (10) begin
            @(negedge clk160);
            if (!link_status.locked) begin
                saw_drop = 1'b1;
                if (link_status.state != locked_wait && link_status.state != locked_check)
                    report_mismatch("state left lock on a stuck line");
            end
        end
        stuck_mode = 1'b0;
        check_flag(saw_drop, 1'b1, "locked cleared on stuck line");
        while (!link_status.locked)
            @(negedge clk160);

        // broken headers from the next full frame on
        corrupt_from = (word_idx * word_width + frame_width - skew) / frame_width + 1;
        last_err     = link_status.err_cnt;
        while (link_status.state != idle) begin
            @(negedge clk160);
            if (link_status.err_cnt != last_err && link_status.err_cnt != last_err + 5'd1)
                report_mismatch("error count skipped a step");
            last_err = link_status.err_cnt;
        end
        exp_status = '{state: idle, locked: 1'b0,
                       sync_cnt: lock_threshold + 9'd1, err_cnt: unlock_err};
        check_status(link_status, exp_status, "status after loss of lock");

        if (error_count == 0) begin
            $display("Regression passed");
            $finish;
        end else begin
            abort_run("checks reported errors");
        end
    end

endmodule

//--- sim.f
source/link_frame_pkg.sv
source/link_sync_pkg.sv
source/word_gatherer.sv
source/frame_aligner.sv
source/sync_tracker.sv
source/packet_serializer.sv
source/strip_link_top.sv
tests/strip_link_tb.sv
